//--- common/alu_defines.svh
////////////////////
// Widths fixed by RV64I, one register copy, no renaming.
////////////////////

`ifndef ALU_DEFINES_SVH
`define ALU_DEFINES_SVH

// Data path width.
`define XLEN 64

// Architectural integer registers.
`define REG_NUM 32

// Must cover REG_NUM entries.
`define REG_AW 5

`endif

//--- common/alu_pkg.sv
////////////////////
// Shared types for the execute lane, widths from alu_defines.svh.
////////////////////

`default_nettype none

`include "alu_defines.svh"

package alu_pkg;

	typedef logic [`XLEN-1:0]   xlen_t;
	typedef logic [`REG_AW-1:0] reg_addr_t;
	typedef logic [31:0]        instr_t;

	// Number of ALU functions.
	localparam int FUN_NUM = 10;

	// One-hot, exactly one bit set for a valid bundle.
	typedef logic [FUN_NUM-1:0] alu_fun_t;

	// Bit positions in alu_fun_t.
	localparam int FUN_IMM = 0; // PC or zero, plus imm.
	localparam int FUN_ADD = 1;
	localparam int FUN_SUB = 2;
	localparam int FUN_SLT = 3; // Signed or unsigned by flag.
	localparam int FUN_XOR = 4;
	localparam int FUN_OR  = 5;
	localparam int FUN_AND = 6;
	localparam int FUN_SLL = 7;
	localparam int FUN_SRL = 8;
	localparam int FUN_SRA = 9;

endpackage

`default_nettype wire

//--- common/exe_param_if.sv
////////////////////
// Bundle is only meaningful while valid is high.
////////////////////

`timescale 1ns/1ps
`default_nettype none

interface exe_param_if;

	logic              valid;       // One-cycle strobe per instruction.
	alu_pkg::alu_fun_t fun;
	logic              is32w;       // W form, result from bit 31.
	logic              is_unsigned;
	logic              is_imm;      // Second operand is imm.
	logic              is_shamt;    // Shift amount from imm.
	logic              use_pc;      // AUIPC.
	alu_pkg::reg_addr_t rs1;
	alu_pkg::reg_addr_t rs2;
	alu_pkg::reg_addr_t rd;
	alu_pkg::xlen_t    pc;
	alu_pkg::xlen_t    imm;

	// Decode side.
	modport decode_mp (
		output valid, fun, is32w, is_unsigned, is_imm, is_shamt, use_pc,
		output rs1, rs2, rd, pc, imm
	);

	// Execute side.
	modport exec_mp (
		input valid, fun, is32w, is_unsigned, is_imm, is_shamt, use_pc,
		input rs1, rs2, rd, pc, imm
	);

endinterface

`default_nettype wire

//--- common/reg_read_if.sv
////////////////////
// Read data returns combinationally in the same cycle.
////////////////////

`timescale 1ns/1ps
`default_nettype none

interface reg_read_if;

	alu_pkg::reg_addr_t rs1_addr;
	alu_pkg::reg_addr_t rs2_addr;
	alu_pkg::xlen_t     rs1_data;
	alu_pkg::xlen_t     rs2_data;

	modport exec_mp (
		output rs1_addr, rs2_addr,
		input  rs1_data, rs2_data
	);

	modport rf_mp (
		input  rs1_addr, rs2_addr,
		output rs1_data, rs2_data
	);

endinterface

`default_nettype wire

//--- decode/instr_decode.sv
////////////////////
// OP, OP-IMM, OP-32, OP-IMM-32, LUI, AUIPC only; others are dropped.
////////////////////

`timescale 1ns/1ps
`default_nettype none

module instr_decode (
	input  logic              CLK,
	input  logic              rst,
	input  logic              flush,
	input  logic              instr_valid,
	input  alu_pkg::instr_t   instr,
	input  alu_pkg::xlen_t    pc,
	exe_param_if.decode_mp    ep
);

	localparam logic [6:0] OPC_OP      = 7'b0110011;
	localparam logic [6:0] OPC_OPIMM   = 7'b0010011;
	localparam logic [6:0] OPC_OP32    = 7'b0111011;
	localparam logic [6:0] OPC_OPIMM32 = 7'b0011011;
	localparam logic [6:0] OPC_LUI     = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC   = 7'b0010111;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic       f7_zero;
	logic       f7_alt;     // Bit 30 set, SUB or SRA.
	logic       sh6_zero;   // RV64 shift imm, bits 31:26.
	logic       sh6_alt;

	alu_pkg::xlen_t    imm_i;
	alu_pkg::xlen_t    imm_u;
	alu_pkg::alu_fun_t fun;
	alu_pkg::xlen_t    imm;
	logic dec_ok;
	logic is32w, is_unsigned, is_imm, is_shamt, use_pc;

	assign opcode   = instr[6:0];
	assign funct3   = instr[14:12];
	assign funct7   = instr[31:25];
	assign f7_zero  = (funct7 == 7'b0000000);
	assign f7_alt   = (funct7 == 7'b0100000);
	assign sh6_zero = (instr[31:26] == 6'b000000);
	assign sh6_alt  = (instr[31:26] == 6'b010000);

	assign imm_i = {{52{instr[31]}}, instr[31:20]};
	assign imm_u = {{32{instr[31]}}, instr[31:12], 12'b0};

	always_comb begin
		dec_ok      = 1'b0;
		fun         = '0;
		is32w       = 1'b0;
		is_unsigned = 1'b0;
		is_imm      = 1'b0;
		is_shamt    = 1'b0;
		use_pc      = 1'b0;
		imm         = imm_i;
		case (opcode)
			OPC_OP, OPC_OP32, OPC_OPIMM, OPC_OPIMM32: begin
				is32w  = opcode[3];  // Set in both 32-bit opcodes.
				is_imm = ~opcode[5]; // Clear in both immediate opcodes.
				case (funct3)
					3'b000: begin
						fun[(~is_imm & funct7[5]) ? alu_pkg::FUN_SUB : alu_pkg::FUN_ADD] = 1'b1;
						dec_ok = is_imm | f7_zero | f7_alt;
					end
					3'b001: begin
						fun[alu_pkg::FUN_SLL] = 1'b1;
						is_shamt = is_imm;
						dec_ok = (is32w | ~is_imm) ? f7_zero : sh6_zero;
					end
					3'b010, 3'b011: begin
						fun[alu_pkg::FUN_SLT] = 1'b1;
						is_unsigned = funct3[0];
						dec_ok = ~is32w & (is_imm | f7_zero); // No W form.
					end
					3'b100: begin
						fun[alu_pkg::FUN_XOR] = 1'b1;
						dec_ok = ~is32w & (is_imm | f7_zero);
					end
					3'b110: begin
						fun[alu_pkg::FUN_OR] = 1'b1;
						dec_ok = ~is32w & (is_imm | f7_zero);
					end
					3'b111: begin
						fun[alu_pkg::FUN_AND] = 1'b1;
						dec_ok = ~is32w & (is_imm | f7_zero);
					end
					default: begin // 3'b101
						fun[funct7[5] ? alu_pkg::FUN_SRA : alu_pkg::FUN_SRL] = 1'b1;
						is_shamt = is_imm;
						dec_ok = (is32w | ~is_imm) ? (f7_zero | f7_alt) : (sh6_zero | sh6_alt);
					end
				endcase
			end
			OPC_LUI, OPC_AUIPC: begin
				fun[alu_pkg::FUN_IMM] = 1'b1;
				is_imm = 1'b1;
				use_pc = opcode[5] == 1'b0; // AUIPC.
				imm    = imm_u;
				dec_ok = 1'b1;
			end
			default: dec_ok = 1'b0;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			ep.valid       <= 1'b0;
			ep.fun         <= '0;
			ep.is32w       <= 1'b0;
			ep.is_unsigned <= 1'b0;
			ep.is_imm      <= 1'b0;
			ep.is_shamt    <= 1'b0;
			ep.use_pc      <= 1'b0;
			ep.rs1         <= '0;
			ep.rs2         <= '0;
			ep.rd          <= '0;
			ep.pc          <= '0;
			ep.imm         <= '0;
		end else begin
			ep.valid       <= instr_valid & dec_ok & ~flush;
			ep.fun         <= fun;
			ep.is32w       <= is32w;
			ep.is_unsigned <= is_unsigned;
			ep.is_imm      <= is_imm;
			ep.is_shamt    <= is_shamt;
			ep.use_pc      <= use_pc;
			ep.rs1         <= instr[19:15];
			ep.rs2         <= instr[24:20];
			ep.rd          <= instr[11:7];
			ep.pc          <= pc;
			ep.imm         <= imm;
		end
	end

endmodule

`default_nettype wire

//--- execute/alu_execute.sv
////////////////////
// One result per cycle, registered; flush kills the one being computed.
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "alu_defines.svh"

module alu_execute (
	input  logic               CLK,
	input  logic               rst,
	input  logic               flush,
	exe_param_if.exec_mp       ep,
	reg_read_if.exec_mp        rd_port,
	output logic               wb_valid,
	output alu_pkg::reg_addr_t wb_rd,
	output alu_pkg::xlen_t     wb_data
);

	// Sign-extend a W result from bit 31.
	function automatic alu_pkg::xlen_t sext32(input logic [31:0] v);
		return {{(`XLEN-32){v[31]}}, v};
	endfunction

	alu_pkg::xlen_t src1, src2;
	alu_pkg::xlen_t adder_op1, adder_op2, adder_sum, add_res;
	alu_pkg::xlen_t log_op2, xor_res, or_res, and_res, slt_res;
	alu_pkg::xlen_t shl, shl_res, shr_res, alu_res;
	logic                     is_sub, slt_lt;
	logic [5:0]               amt_src, shamt;
	logic signed [`XLEN:0]    shr_op, shr_full; // One extra bit carries the fill.

	assign rd_port.rs1_addr = ep.rs1;
	assign rd_port.rs2_addr = ep.rs2;
	assign src1 = rd_port.rs1_data;
	assign src2 = rd_port.rs2_data;

	assign is_sub = ep.fun[alu_pkg::FUN_SUB];

	// Adder, shared by IMM, ADD and SUB.
	assign adder_op1 = ({`XLEN{ep.fun[alu_pkg::FUN_IMM] & ep.use_pc}} & ep.pc)
		| ({`XLEN{ep.fun[alu_pkg::FUN_ADD] | is_sub}} & src1);
	assign adder_op2 = ({`XLEN{ep.is_imm}} & ep.imm)
		| ({`XLEN{ep.fun[alu_pkg::FUN_ADD] & ~ep.is_imm}} & src2)
		| ({`XLEN{is_sub}} & ~src2); // Carry-in completes the negate.
	assign adder_sum = adder_op1 + adder_op2 + {{(`XLEN-1){1'b0}}, is_sub};
	assign add_res   = ep.is32w ? sext32(adder_sum[31:0]) : adder_sum;

	assign log_op2 = ep.is_imm ? ep.imm : src2;
	assign xor_res = src1 ^ log_op2;
	assign or_res  = src1 | log_op2;
	assign and_res = src1 & log_op2;

	assign slt_lt  = ep.is_unsigned ? (src1 < log_op2) : ($signed(src1) < $signed(log_op2));
	assign slt_res = {{(`XLEN-1){1'b0}}, slt_lt};

	// W forms only see 5 bits of shift amount.
	assign amt_src = ep.is_shamt ? ep.imm[5:0] : src2[5:0];
	assign shamt   = ep.is32w ? {1'b0, amt_src[4:0]} : amt_src;

	assign shl     = src1 << shamt;
	assign shl_res = ep.is32w ? sext32(shl[31:0]) : shl;

	// W right shift works on the low word, fill is the sign only for SRA.
	always_comb begin
		if (ep.is32w)
			shr_op = {{(`XLEN-31){src1[31] & ep.fun[alu_pkg::FUN_SRA]}}, src1[31:0]};
		else
			shr_op = {src1[`XLEN-1] & ep.fun[alu_pkg::FUN_SRA], src1};
	end

	assign shr_full = shr_op >>> shamt;
	assign shr_res  = ep.is32w ? sext32(shr_full[31:0]) : shr_full[`XLEN-1:0];

	assign alu_res =
		  ({`XLEN{ep.fun[alu_pkg::FUN_IMM] | ep.fun[alu_pkg::FUN_ADD] | is_sub}} & add_res)
		| ({`XLEN{ep.fun[alu_pkg::FUN_SLT]}} & slt_res)
		| ({`XLEN{ep.fun[alu_pkg::FUN_XOR]}} & xor_res)
		| ({`XLEN{ep.fun[alu_pkg::FUN_OR]}}  & or_res)
		| ({`XLEN{ep.fun[alu_pkg::FUN_AND]}} & and_res)
		| ({`XLEN{ep.fun[alu_pkg::FUN_SLL]}} & shl_res)
		| ({`XLEN{ep.fun[alu_pkg::FUN_SRL] | ep.fun[alu_pkg::FUN_SRA]}} & shr_res);

	always_ff @(posedge CLK) begin
		if (rst) begin
			wb_valid <= 1'b0;
			wb_rd    <= '0;
			wb_data  <= '0;
		end else begin
			wb_valid <= ep.valid & ~flush;
			wb_rd    <= ep.rd;
			wb_data  <= alu_res;
		end
	end

endmodule

`default_nettype wire

//--- result/reg_writeback.sv
////////////////////
// x0 reads zero; both read ports bypass the writeback bus.
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "alu_defines.svh"

module reg_writeback (
	input  logic               CLK,
	input  logic               rst,
	input  logic               wb_valid,
	input  alu_pkg::reg_addr_t wb_rd,
	input  alu_pkg::xlen_t     wb_data,
	reg_read_if.rf_mp          rd_port
);

	alu_pkg::xlen_t rf [`REG_NUM];
	logic           wr_en;

	// Same read path for both ports.
	function automatic alu_pkg::xlen_t read_reg(input alu_pkg::reg_addr_t addr,
			input logic fwd_en, input alu_pkg::reg_addr_t fwd_rd,
			input alu_pkg::xlen_t fwd_data, input alu_pkg::xlen_t stored);
		if (addr == '0)
			return '0;
		else if (fwd_en && addr == fwd_rd)
			return fwd_data; // Result not yet in the file.
		else
			return stored;
	endfunction

	assign wr_en = wb_valid & (wb_rd != '0);

	always_ff @(posedge CLK) begin
		if (rst) begin
			for (int i = 0; i < `REG_NUM; i++)
				rf[i] <= '0;
		end else if (wr_en) begin
			rf[wb_rd] <= wb_data;
		end
	end

	assign rd_port.rs1_data = read_reg(rd_port.rs1_addr, wb_valid, wb_rd, wb_data,
		rf[rd_port.rs1_addr]);
	assign rd_port.rs2_data = read_reg(rd_port.rs2_addr, wb_valid, wb_rd, wb_data,
		rf[rd_port.rs2_addr]);

endmodule

`default_nettype wire

//--- src/int_exec_top.sv
////////////////////
// Two cycles from instr_valid to wb_valid, no stall, no back-pressure.
////////////////////

`timescale 1ns/1ps
`default_nettype none

module int_exec_top (
	input  logic               CLK,
	input  logic               rst,
	input  logic               instr_valid,
	input  alu_pkg::instr_t    instr,
	input  alu_pkg::xlen_t     pc,
	input  logic               flush,
	output logic               wb_valid,
	output alu_pkg::reg_addr_t wb_rd,
	output alu_pkg::xlen_t     wb_data
);

	exe_param_if ep_if ();
	reg_read_if  rd_if ();

	instr_decode u_decode (
		.CLK         (CLK),
		.rst         (rst),
		.flush       (flush),
		.instr_valid (instr_valid),
		.instr       (instr),
		.pc          (pc),
		.ep          (ep_if.decode_mp)
	);

	alu_execute u_execute (
		.CLK      (CLK),
		.rst      (rst),
		.flush    (flush),
		.ep       (ep_if.exec_mp),
		.rd_port  (rd_if.exec_mp),
		.wb_valid (wb_valid),
		.wb_rd    (wb_rd),
		.wb_data  (wb_data)
	);

	// Writeback bus also feeds the read bypass.
	reg_writeback u_result (
		.CLK      (CLK),
		.rst      (rst),
		.wb_valid (wb_valid),
		.wb_rd    (wb_rd),
		.wb_data  (wb_data),
		.rd_port  (rd_if.rf_mp)
	);

endmodule

`default_nettype wire

//--- verification/int_exec_tb.sv
////////////////////
// Stops at the first mismatch. Model register file follows in-order writeback.
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "alu_defines.svh"

module int_exec_tb;

	localparam logic [6:0] OPC_OP      = 7'b0110011;
	localparam logic [6:0] OPC_OPIMM   = 7'b0010011;
	localparam logic [6:0] OPC_OP32    = 7'b0111011;
	localparam logic [6:0] OPC_OPIMM32 = 7'b0011011;
	localparam logic [6:0] OPC_LUI     = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC   = 7'b0010111;
	localparam logic [6:0] OPC_STORE   = 7'b0100011;

	logic               CLK;
	logic               rst;
	logic               instr_valid;
	alu_pkg::instr_t    instr;
	alu_pkg::xlen_t     pc;
	logic               flush;
	logic               wb_valid;
	alu_pkg::reg_addr_t wb_rd;
	alu_pkg::xlen_t     wb_data;

	alu_pkg::xlen_t     model_rf [`REG_NUM];
	alu_pkg::reg_addr_t exp_rd_q [$];    // Expected writebacks, oldest first.
	alu_pkg::xlen_t     exp_data_q [$];
	int                 exp_cycle_q [$]; // Cycle of issue.
	string              exp_name_q [$];
	int                 cycle;

	int_exec_top UUT (
		.CLK         (CLK),
		.rst         (rst),
		.instr_valid (instr_valid),
		.instr       (instr),
		.pc          (pc),
		.flush       (flush),
		.wb_valid    (wb_valid),
		.wb_rd       (wb_rd),
		.wb_data     (wb_data)
	);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Errors found");
		$fatal(1, "Stopping at first error.");
	endtask

	function automatic alu_pkg::instr_t r_format(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
			input logic [6:0] opc);
		return {f7, rs2, rs1, f3, rd, opc};
	endfunction

	function automatic alu_pkg::instr_t i_format(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic alu_pkg::instr_t u_format(input logic [19:0] imm, input logic [4:0] rd,
			input logic [6:0] opc);
		return {imm, rd, opc};
	endfunction

	// Destinations 3 to 30; x1, x2 hold sources and x31 is scratch.
	function automatic alu_pkg::reg_addr_t rand_reg();
		return alu_pkg::reg_addr_t'($urandom_range(30, 3));
	endfunction

	// RV64I semantics on the model registers; returns 0 for unsupported opcodes.
	function automatic logic model_exec(input alu_pkg::instr_t ins, input alu_pkg::xlen_t pc_v,
			output alu_pkg::xlen_t res);
		alu_pkg::xlen_t a;
		alu_pkg::xlen_t b;
		alu_pkg::xlen_t u_imm;
		logic [31:0]    w;
		logic [5:0]     sh;
		logic           ok;
		a     = model_rf[ins[19:15]];
		b     = ins[5] ? model_rf[ins[24:20]] : {{52{ins[31]}}, ins[31:20]};
		u_imm = {{32{ins[31]}}, ins[31:12], 12'b0};
		ok    = 1'b1;
		res   = '0;
		w     = '0;
		case (ins[6:0])
			OPC_LUI:   res = u_imm;
			OPC_AUIPC: res = pc_v + u_imm;
			OPC_OP, OPC_OPIMM: begin
				sh = b[5:0];
				case (ins[14:12])
					3'b000: res = (ins[5] && ins[30]) ? a - b : a + b;
					3'b001: res = a << sh;
					3'b010: res = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
					3'b011: res = (a < b) ? 64'd1 : 64'd0;
					3'b100: res = a ^ b;
					3'b110: res = a | b;
					3'b111: res = a & b;
					default: begin
						if (ins[30])
							res = $signed(a) >>> sh;
						else
							res = a >> sh;
					end
				endcase
			end
			OPC_OP32, OPC_OPIMM32: begin
				sh = {1'b0, b[4:0]};
				case (ins[14:12])
					3'b000: w = (ins[5] && ins[30]) ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
					3'b001: w = a[31:0] << sh;
					3'b101: begin
						if (ins[30])
							w = $signed(a[31:0]) >>> sh;
						else
							w = a[31:0] >> sh;
					end
					default: ok = 1'b0;
				endcase
				res = {{32{w[31]}}, w}; // Sign from bit 31.
			end
			default: ok = 1'b0;
		endcase
		return ok;
	endfunction

	// One cycle; outputs sampled at the falling edge.
	task automatic step();
		@(negedge CLK);
		cycle++;
		instr_valid = 1'b0;
		flush       = 1'b0;
		if (wb_valid)
			check_wb();
	endtask

	task automatic check_wb();
		string              name;
		int                 issued;
		alu_pkg::reg_addr_t e_rd;
		alu_pkg::xlen_t     e_data;
		assert (exp_rd_q.size() != 0)
			else report_failure($sformatf("wb_valid rose for x%0d with nothing in flight", wb_rd));
		name   = exp_name_q.pop_front();
		issued = exp_cycle_q.pop_front();
		e_rd   = exp_rd_q.pop_front();
		e_data = exp_data_q.pop_front();
		assert (cycle - issued == 2)
			else report_failure($sformatf("Fail %s latency expected 2 actual %0d", name,
				cycle - issued));
		assert (wb_rd == e_rd)
			else report_failure($sformatf("Fail %s rd expected %0d actual %0d", name, e_rd, wb_rd));
		assert (wb_data == e_data)
			else report_failure($sformatf("Fail %s data expected %h actual %h", name, e_data,
				wb_data));
	endtask

	// Drive one instruction; keep clear means it is expected to be lost.
	task automatic issue(input alu_pkg::instr_t ins, input alu_pkg::xlen_t pc_v,
			input string name, input logic keep);
		alu_pkg::xlen_t res;
		logic           ok;
		ok = model_exec(ins, pc_v, res);
		step();
		instr_valid = 1'b1;
		instr       = ins;
		pc          = pc_v;
		if (ok && keep) begin
			exp_rd_q.push_back(ins[11:7]);
			exp_data_q.push_back(res);
			exp_cycle_q.push_back(cycle);
			exp_name_q.push_back(name);
			if (ins[11:7] != 5'd0)
				model_rf[ins[11:7]] = res;
		end
	endtask

	task automatic drain();
		int n;
		n = 0;
		while (exp_rd_q.size() != 0) begin
			assert (n < 10)
				else report_failure("Timeout, no wb_valid within 10 cycles.");
			step();
			n++;
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n)
			step();
	endtask

	// Random 64-bit value built from LUI, SLLI, XOR, XORI.
	task automatic fill_reg(input alu_pkg::reg_addr_t r);
		issue(u_format(20'($urandom), r, OPC_LUI), '0, "fill lui", 1'b1);
		issue(i_format(12'd32, r, 3'b001, r, OPC_OPIMM), '0, "fill slli", 1'b1);
		issue(u_format(20'($urandom), 5'd31, OPC_LUI), '0, "fill lui", 1'b1);
		issue(r_format(7'h00, 5'd31, r, 3'b100, r, OPC_OP), '0, "fill xor", 1'b1);
		issue(i_format(12'($urandom), r, 3'b100, r, OPC_OPIMM), '0, "fill xori", 1'b1);
	endtask

	task automatic upper_imm_test();
		alu_pkg::xlen_t base;
		fill_reg(5'd1);
		repeat (4) begin
			base = {$urandom, $urandom} & ~64'h3;
			issue(u_format(20'($urandom), rand_reg(), OPC_LUI), base, "upper lui", 1'b1);
			issue(u_format(20'($urandom), rand_reg(), OPC_AUIPC), base, "upper auipc", 1'b1);
			issue(i_format(12'($urandom), 5'd1, 3'b000, rand_reg(), OPC_OPIMM), base,
				"upper addi", 1'b1);
			drain();
		end
	endtask

	task automatic dependent_ops_test();
		repeat (3) begin
			fill_reg(5'd1);
			fill_reg(5'd2);
			// x1 negative, x2 positive, so SLT and SLTU differ.
			if (!model_rf[1][63])
				issue(r_format(7'h20, 5'd1, 5'd0, 3'b000, 5'd1, OPC_OP), '0, "dep neg", 1'b1);
			if (model_rf[2][63])
				issue(r_format(7'h20, 5'd2, 5'd0, 3'b000, 5'd2, OPC_OP), '0, "dep neg", 1'b1);
			issue(r_format(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, OPC_OP), '0, "dep add", 1'b1);
			issue(r_format(7'h20, 5'd2, 5'd3, 3'b000, 5'd4, OPC_OP), '0, "dep sub", 1'b1);
			issue(r_format(7'h00, 5'd2, 5'd4, 3'b010, 5'd5, OPC_OP), '0, "dep slt", 1'b1);
			issue(r_format(7'h00, 5'd2, 5'd4, 3'b011, 5'd6, OPC_OP), '0, "dep sltu", 1'b1);
			issue(r_format(7'h00, 5'd1, 5'd6, 3'b100, 5'd7, OPC_OP), '0, "dep xor", 1'b1);
			issue(r_format(7'h00, 5'd2, 5'd7, 3'b110, 5'd8, OPC_OP), '0, "dep or", 1'b1);
			issue(r_format(7'h00, 5'd3, 5'd8, 3'b111, 5'd9, OPC_OP), '0, "dep and", 1'b1);
			drain();
		end
	endtask

	task automatic shift_test();
		logic [5:0] sh6;
		logic [4:0] sh5;
		repeat (3) begin
			fill_reg(5'd1);
			fill_reg(5'd2);
			sh6 = {1'b1, 5'($urandom)}; // Above 31.
			sh5 = 5'($urandom);
			issue(r_format(7'h00, 5'd2, 5'd1, 3'b001, 5'd3, OPC_OP), '0, "shift sll", 1'b1);
			issue(r_format(7'h00, 5'd2, 5'd1, 3'b101, 5'd4, OPC_OP), '0, "shift srl", 1'b1);
			issue(r_format(7'h20, 5'd2, 5'd1, 3'b101, 5'd5, OPC_OP), '0, "shift sra", 1'b1);
			issue(i_format({6'b000000, sh6}, 5'd1, 3'b001, 5'd6, OPC_OPIMM), '0, "shift slli", 1'b1);
			issue(i_format({6'b010000, sh6}, 5'd1, 3'b101, 5'd7, OPC_OPIMM), '0, "shift srai", 1'b1);
			issue(r_format(7'h00, 5'd2, 5'd1, 3'b000, 5'd8, OPC_OP32), '0, "shift addw", 1'b1);
			issue(r_format(7'h20, 5'd2, 5'd1, 3'b000, 5'd9, OPC_OP32), '0, "shift subw", 1'b1);
			issue(r_format(7'h00, 5'd2, 5'd1, 3'b001, 5'd10, OPC_OP32), '0, "shift sllw", 1'b1);
			issue(r_format(7'h00, 5'd2, 5'd1, 3'b101, 5'd11, OPC_OP32), '0, "shift srlw", 1'b1);
			issue(r_format(7'h20, 5'd2, 5'd1, 3'b101, 5'd12, OPC_OP32), '0, "shift sraw", 1'b1);
			issue(i_format({7'b0100000, sh5}, 5'd1, 3'b101, 5'd13, OPC_OPIMM32), '0,
				"shift sraiw", 1'b1);
			drain();
		end
	endtask

	task automatic flush_test();
		fill_reg(5'd1);
		fill_reg(5'd2);
		drain();
		issue(r_format(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, OPC_OP), '0, "flush add", 1'b0);
		issue(r_format(7'h20, 5'd2, 5'd1, 3'b000, 5'd4, OPC_OP), '0, "flush sub", 1'b0);
		flush = 1'b1; // Kills the ADD in execute and the SUB at the input.
		idle_cycles(5);
		issue(r_format(7'h00, 5'd0, 5'd3, 3'b000, 5'd10, OPC_OP), '0, "flush read x3", 1'b1);
		issue(r_format(7'h00, 5'd0, 5'd4, 3'b000, 5'd11, OPC_OP), '0, "flush read x4", 1'b1);
		drain();
	endtask

	task automatic x0_test();
		fill_reg(5'd1);
		issue(i_format(12'($urandom), 5'd1, 3'b000, 5'd0, OPC_OPIMM), '0, "x0 addi", 1'b1);
		issue(r_format(7'h00, 5'd1, 5'd0, 3'b000, 5'd5, OPC_OP), '0, "x0 add rs1", 1'b1);
		issue(r_format(7'h00, 5'd0, 5'd1, 3'b000, 5'd6, OPC_OP), '0, "x0 add rs2", 1'b1);
		drain();
	endtask

	task automatic unsupported_test();
		issue(r_format(7'($urandom), 5'd2, 5'd1, 3'b011, 5'($urandom), OPC_STORE), '0,
			"store", 1'b1); // Model drops it too.
		idle_cycles(5);
		issue(i_format(12'($urandom), 5'd1, 3'b000, 5'd7, OPC_OPIMM), '0, "after store", 1'b1);
		drain();
	endtask

	initial begin
		rst         = 1'b1;
		instr_valid = 1'b0;
		instr       = '0;
		pc          = '0;
		flush       = 1'b0;
		cycle       = 0;
		for (int i = 0; i < `REG_NUM; i++)
			model_rf[i] = '0;
		void'($urandom(90));
		repeat (2) @(posedge CLK);
		step();
		rst = 1'b0;
		upper_imm_test();
		dependent_ops_test();
		shift_test();
		flush_test();
		x0_test();
		unsupported_test();
		drain();
		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
+incdir+common
common/alu_pkg.sv
common/exe_param_if.sv
common/reg_read_if.sv
decode/instr_decode.sv
execute/alu_execute.sv
result/reg_writeback.sv
src/int_exec_top.sv
verification/int_exec_tb.sv
